// ==== hdl/usb_txn_pkg.sv ====
/*
 * USB full-speed transaction layer definitions
 * PID and endpoint codes, receive/transmit packet structs,
 * transaction event strobes, setup word union, request match values
 */
package usb_txn_pkg;

    // ------------------------------------------------------------
    // codes
    // ------------------------------------------------------------
    typedef logic [3:0] pid_t;
    typedef logic [3:0] endp_t;
    typedef logic [9:0] pkt_cnt_t;                  // bytes left in one packet

    localparam pid_t PID_OUT   = 4'h1;
    localparam pid_t PID_IN    = 4'h9;
    localparam pid_t PID_SETUP = 4'hD;
    localparam pid_t PID_DATA0 = 4'h3;
    localparam pid_t PID_DATA1 = 4'hB;
    localparam pid_t PID_ACK   = 4'h2;
    localparam pid_t PID_NAK   = 4'hA;

    localparam endp_t EP_CTRL = 4'd0;               // control endpoint
    localparam endp_t EP_IN1  = 4'd1;               // bulk IN 0x81
    localparam endp_t EP_OUT1 = 4'd1;               // bulk OUT 0x01

    // ------------------------------------------------------------
    // packet interfaces
    // ------------------------------------------------------------
    typedef struct packed {
        pid_t       pid;                            // pid of current packet
        endp_t      endp;                           // token endpoint field
        logic       byte_en;                        // payload byte strobe
        logic [7:0] data;
        logic       fin;                            // packet end
        logic       okay;                           // checks passed, valid with fin
    } rx_pkt_t;

    typedef struct packed {
        logic       sta;                            // start a reply packet
        pid_t       pid;
        logic [7:0] data;                           // answer to a byte request
        logic       fin_n;                          // low after a request ends the packet
    } tx_pkt_t;

    typedef struct packed {
        logic       in_tok;                         // IN token, any endpoint
        logic       data_end;                       // DATA0/1 received ok
        logic       ctrl_in;                        // IN token on endpoint 0
        logic       setup_end;                      // setup stage data done
        logic       ctrl_out_end;                   // endpoint 0 OUT data done
        logic [2:0] endp;
    } txn_evt_t;

    // ------------------------------------------------------------
    // setup command
    // ------------------------------------------------------------
    typedef struct packed {
        logic [15:0] w_length;
        logic [15:0] w_index;
        logic [15:0] w_value;
        logic [7:0]  b_request;
        logic [7:0]  bm_request_type;               // bit 7 set = device to host
    } setup_fields_t;

    typedef union packed {
        logic [63:0]   raw;                         // first received byte in [7:0]
        setup_fields_t fld;
    } setup_cmd_u;

    // low half of the setup word; zero bytes are not compared
    localparam logic [31:0] REQ_GET_CONFIG      = 32'h0000_08_80;
    localparam logic [31:0] REQ_GET_DESC_DEVICE = 32'h0100_06_80;

    localparam int unsigned DEV_DESC_BYTES = 18;

endpackage

// ==== hdl/token_tracker.sv ====
/*
 * Token tracker: turns received packet ends into event strobes,
 * keeps the current endpoint, setup stage and DATA0/1 toggles
 */
`timescale 1ns/10ps

module token_tracker (
    input  logic                 clk,
    input  logic                 rstn,
    input  usb_txn_pkg::rx_pkt_t rx,
    output usb_txn_pkg::txn_evt_t evt,
    output usb_txn_pkg::endp_t   cur_endp,
    output logic                 setup_phase,
    output logic                 ctrl_setup_rx,
    output logic                 ctrl_toggle,
    output logic                 in1_toggle
);
    import usb_txn_pkg::*;

    logic pkt_end;

    assign pkt_end       = rx.fin & rx.okay;
    assign ctrl_setup_rx = setup_phase && (cur_endp == EP_CTRL);   // setup bytes go to ep0

    // ------------------------------------------------------------
    // token decode
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            evt         <= '0;
            cur_endp    <= EP_CTRL;
            setup_phase <= 1'b0;
            ctrl_toggle <= 1'b0;
            in1_toggle  <= 1'b0;
        end else begin
            evt <= '0;                                       // strobes last one cycle
            if (pkt_end) begin
                case (rx.pid)
                    PID_SETUP: begin
                        cur_endp <= rx.endp;
                        if (rx.endp == EP_CTRL) begin
                            setup_phase <= 1'b1;
                            ctrl_toggle <= 1'b1;             // data stage starts at DATA1
                        end
                    end
                    PID_OUT: begin
                        cur_endp <= rx.endp;
                        if (rx.endp == EP_CTRL)
                            setup_phase <= 1'b0;
                    end
                    PID_IN: begin
                        cur_endp    <= rx.endp;
                        evt.in_tok  <= 1'b1;
                        evt.endp    <= rx.endp[2:0];
                        if (rx.endp == EP_CTRL) begin
                            setup_phase <= 1'b0;
                            evt.ctrl_in <= 1'b1;
                        end
                    end
                    PID_ACK: begin                           // host accepted our data
                        if (cur_endp == EP_CTRL)
                            ctrl_toggle <= ~ctrl_toggle;
                        else if (cur_endp == EP_IN1)
                            in1_toggle  <= ~in1_toggle;
                    end
                    PID_DATA0, PID_DATA1: begin
                        evt.data_end <= 1'b1;
                        evt.endp     <= cur_endp[2:0];
                        if (cur_endp == EP_CTRL) begin
                            evt.setup_end    <= setup_phase;
                            evt.ctrl_out_end <= ~setup_phase;
                        end
                    end
                    default: ;                               // other pids ignored
                endcase
            end
        end
    end

endmodule

// ==== hdl/ctrl_endpoint.sv ====
/*
 * Control endpoint 0: setup capture, remaining length and
 * response index, response byte for standard and user requests
 */
`timescale 1ns/10ps

module ctrl_endpoint #(
    parameter logic [7:0]   CTRL_MAXPKT = 8'd8,
    parameter logic [143:0] DEVICE_DESC = '0
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  usb_txn_pkg::rx_pkt_t     rx,
    input  logic                     ctrl_setup_rx,
    input  logic                     setup_end,
    input  logic                     ctrl_out_end,
    input  logic                     ctrl_in,
    input  logic                     ctrl_byte_take,
    output usb_txn_pkg::pkt_cnt_t    ctrl_len,
    output logic [7:0]               ctrl_byte,
    output usb_txn_pkg::setup_cmd_u  setup_cmd,
    output logic [8:0]               resp_idx,
    input  logic [7:0]               user_resp
);
    import usb_txn_pkg::*;

    logic [15:0] ctrl_total;                                 // bytes left in the data stage
    logic        is_get_config;
    logic        is_get_dev_desc;
    logic [4:0]  desc_idx;

    // ------------------------------------------------------------
    // setup word and data stage length
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            setup_cmd <= '0;
        end else if (ctrl_setup_rx && rx.byte_en) begin
            setup_cmd.raw <= {rx.data, setup_cmd.raw[63:8]};   // shift in, lsb byte first
        end
    end

    // one packet worth, or whatever is left
    assign ctrl_len = (ctrl_total >= {8'h00, CTRL_MAXPKT}) ? {2'b00, CTRL_MAXPKT}
                                                          : {2'b00, ctrl_total[7:0]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_total <= '0;
            resp_idx   <= '0;
        end else begin
            if (setup_end) begin
                // only device-to-host requests have an IN data stage
                ctrl_total <= setup_cmd.fld.bm_request_type[7] ? setup_cmd.fld.w_length
                                                               : 16'h0000;
                resp_idx   <= '0;
            end else if (ctrl_out_end) begin
                ctrl_total <= '0;                            // status stage, nothing to send
            end else if (ctrl_in) begin
                ctrl_total <= ctrl_total - {6'd0, ctrl_len};
            end
            if (ctrl_byte_take)
                resp_idx <= resp_idx + 9'd1;
        end
    end

    // ------------------------------------------------------------
    // response byte
    // ------------------------------------------------------------
    assign is_get_config   = (setup_cmd.raw[15:0] == REQ_GET_CONFIG[15:0]);
    assign is_get_dev_desc = (setup_cmd.raw[31:24] == REQ_GET_DESC_DEVICE[31:24]) &&
                             (setup_cmd.raw[15:0]  == REQ_GET_DESC_DEVICE[15:0]);
    assign desc_idx        = 5'(DEV_DESC_BYTES - 1) - resp_idx[4:0];   // msb byte goes first

    always_ff @(posedge clk) begin
        if (is_get_config)
            ctrl_byte <= (resp_idx == 9'd0) ? 8'h01 : 8'h00;            // configuration 1
        else if (is_get_dev_desc)
            ctrl_byte <= (resp_idx >= 9'(DEV_DESC_BYTES)) ? 8'h00
                                                          : DEVICE_DESC[desc_idx*8 +: 8];
        else
            ctrl_byte <= user_resp;                          // left to the user
    end

endmodule

// ==== hdl/in_packet_sender.sv ====
/*
 * Reply packet sender: handshake and data packet starts,
 * per-packet byte count and byte feed to the transmitter
 */
`timescale 1ns/10ps

module in_packet_sender #(
    parameter logic [9:0] IN1_MAXPKT = 10'd8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  usb_txn_pkg::txn_evt_t  evt,
    input  logic                   ctrl_toggle,
    input  logic                   in1_toggle,
    input  logic                   out1_busy,
    input  usb_txn_pkg::pkt_cnt_t  ctrl_len,
    input  logic [7:0]             ctrl_byte,
    input  logic [7:0]             ep81_data,
    input  logic                   ep81_valid,
    output logic                   ep81_ready,
    input  logic                   byte_req,
    output usb_txn_pkg::tx_pkt_t   tx,
    output logic                   ctrl_byte_take
);
    import usb_txn_pkg::*;

    pkt_cnt_t   tx_cnt;                                      // bytes still to send
    logic [2:0] tx_endp;                                     // source of data bytes
    logic       src_valid;
    logic [7:0] src_byte;
    logic       byte_go;

    // ------------------------------------------------------------
    // byte source select
    // ------------------------------------------------------------
    assign src_valid = (tx_endp == EP_CTRL[2:0]) ? 1'b1 : ep81_valid;
    assign src_byte  = (tx_endp == EP_CTRL[2:0]) ? ctrl_byte : ep81_data;
    assign byte_go   = byte_req && (tx_cnt != '0);

    assign ctrl_byte_take = byte_go && (tx_endp == EP_CTRL[2:0]);
    assign ep81_ready     = byte_go && (tx_endp == EP_IN1[2:0]);

    // ------------------------------------------------------------
    // packet start and byte feed
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx      <= '0;
            tx_cnt  <= '0;
            tx_endp <= '0;
        end else begin
            tx.sta <= 1'b0;
            if (evt.in_tok) begin
                tx.sta  <= 1'b1;
                tx_endp <= evt.endp;
                if (evt.endp == EP_CTRL[2:0]) begin
                    tx.pid <= ctrl_toggle ? PID_DATA1 : PID_DATA0;
                    tx_cnt <= ctrl_len;                      // may be zero, status stage
                end else if (evt.endp == EP_IN1[2:0] && ep81_valid) begin
                    tx.pid <= in1_toggle ? PID_DATA1 : PID_DATA0;
                    tx_cnt <= IN1_MAXPKT;
                end else begin
                    tx.pid <= PID_NAK;                       // nothing to give
                    tx_cnt <= '0;
                end
            end else if (evt.data_end) begin
                tx.sta <= 1'b1;
                tx.pid <= out1_busy ? PID_NAK : PID_ACK;
                tx_cnt <= '0;
            end

            if (byte_req) begin
                tx.fin_n <= 1'b0;                            // default: end of packet
                if (byte_go && src_valid) begin
                    tx.fin_n <= 1'b1;
                    tx.data  <= src_byte;
                    tx_cnt   <= tx_cnt - 10'd1;
                end
            end
        end
    end

endmodule

// ==== hdl/out_data_router.sv ====
/*
 * Bulk OUT endpoint 0x01 data router with latched readiness
 */
`timescale 1ns/10ps

module out_data_router (
    input  logic                 clk,
    input  logic                 rstn,
    input  usb_txn_pkg::rx_pkt_t rx,
    input  logic                 data_end,
    input  usb_txn_pkg::endp_t   cur_endp,
    input  logic                 ep01_ready,
    output logic [7:0]           ep01_data,
    output logic                 ep01_valid,
    output logic                 out1_busy
);
    import usb_txn_pkg::*;

    logic ready_r;                                           // readiness at last packet end
    logic on_ep1;

    assign on_ep1    = (cur_endp == EP_OUT1);
    assign out1_busy = on_ep1 && !ep01_ready;                // NAK this data packet

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ready_r    <= 1'b0;
            ep01_valid <= 1'b0;
        end else begin
            if (data_end && on_ep1)
                ready_r <= ep01_ready;
            ep01_valid <= rx.byte_en && on_ep1 && ready_r;
        end
    end

    always_ff @(posedge clk) begin
        if (rx.byte_en && on_ep1)
            ep01_data <= rx.data;
    end

endmodule

// ==== hdl/usb_txn_top.sv ====
/*
 * USB full-speed device transaction layer, top level
 * token tracker, control endpoint, reply sender, OUT router
 */
`timescale 1ns/10ps

module usb_txn_top #(
    parameter logic [7:0]   CTRL_MAXPKT = 8'd8,
    parameter logic [9:0]   IN1_MAXPKT  = 10'd8,
    parameter logic [143:0] DEVICE_DESC =
        144'h12_01_10_01_00_00_00_08_34_12_78_56_00_01_00_00_00_01
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  usb_txn_pkg::rx_pkt_t     rx,           // from packet receiver
    input  logic                     tp_byte_req,
    output usb_txn_pkg::tx_pkt_t     tx,           // to packet transmitter
    output usb_txn_pkg::setup_cmd_u  setup_cmd,
    output logic [8:0]               resp_idx,
    input  logic [7:0]               user_resp,
    input  logic [7:0]               ep81_data,
    input  logic                     ep81_valid,
    output logic                     ep81_ready,
    output logic [7:0]               ep01_data,
    output logic                     ep01_valid,
    input  logic                     ep01_ready
);
    import usb_txn_pkg::*;

    txn_evt_t   evt;
    endp_t      cur_endp;
    logic       ctrl_setup_rx;
    logic       ctrl_toggle;
    logic       in1_toggle;
    pkt_cnt_t   ctrl_len;
    logic [7:0] ctrl_byte;
    logic       ctrl_byte_take;
    logic       out1_busy;

    // ------------------------------------------------------------
    // blocks
    // ------------------------------------------------------------
    token_tracker i_token_tracker (
        .clk, .rstn, .rx, .evt, .cur_endp,
        .setup_phase (),
        .ctrl_setup_rx, .ctrl_toggle, .in1_toggle
    );

    ctrl_endpoint #(
        .CTRL_MAXPKT (CTRL_MAXPKT),
        .DEVICE_DESC (DEVICE_DESC)
    ) i_ctrl_endpoint (
        .clk, .rstn, .rx, .ctrl_setup_rx,
        .setup_end    (evt.setup_end),
        .ctrl_out_end (evt.ctrl_out_end),
        .ctrl_in      (evt.ctrl_in),
        .ctrl_byte_take, .ctrl_len, .ctrl_byte,
        .setup_cmd, .resp_idx, .user_resp
    );

    in_packet_sender #(
        .IN1_MAXPKT (IN1_MAXPKT)
    ) i_in_packet_sender (
        .clk, .rstn, .evt, .ctrl_toggle, .in1_toggle, .out1_busy,
        .ctrl_len, .ctrl_byte, .ep81_data, .ep81_valid, .ep81_ready,
        .byte_req (tp_byte_req),
        .tx, .ctrl_byte_take
    );

    out_data_router i_out_data_router (
        .clk, .rstn, .rx,
        .data_end (evt.data_end),
        .cur_endp, .ep01_ready, .ep01_data, .ep01_valid, .out1_busy
    );

endmodule

// ==== bench/tb_usb_txn.sv ====
/*
 * Testbench for the USB transaction layer
 * host packet model, table of host operations, reply byte collector,
 * expected byte rules and pass/fail report
 */
`timescale 1ns/10ps

module tb_usb_txn;
    import usb_txn_pkg::*;

    localparam logic [143:0] TB_DESC =
        144'h12_01_00_02_ff_00_00_08_ad_de_ef_be_23_01_01_02_03_01;
    localparam int NROWS    = 26;
    localparam int WAIT_MAX = 50;                    // cycles until a reply must start
    localparam int BYTE_MAX = 64;                    // byte requests per packet, bound

    localparam logic [1:0] OP_SETUP = 2'd0;
    localparam logic [1:0] OP_OUT   = 2'd1;
    localparam logic [1:0] OP_IN    = 2'd2;
    localparam logic [1:0] OP_ACK   = 2'd3;          // host handshake, no reply

    localparam logic [2:0] SRC_NONE = 3'd0;
    localparam logic [2:0] SRC_DESC = 3'd1;          // device descriptor, msb byte first
    localparam logic [2:0] SRC_CFG  = 3'd2;          // configuration value
    localparam logic [2:0] SRC_USER = 3'd3;          // index xor 5a
    localparam logic [2:0] SRC_EP81 = 3'd4;          // bytes offered on ep81

    // setup words, first byte on the wire in [7:0]
    localparam logic [63:0] SU_GET_DESC   = 64'h0012_0000_0100_0680;
    localparam logic [63:0] SU_GET_CONFIG = 64'h0004_0000_0000_0880;
    localparam logic [63:0] SU_VENDOR     = 64'h0005_0000_0000_33c0;
    localparam logic [63:0] SU_SET_CONFIG = 64'h0000_0000_0001_0900;

    typedef struct packed {
        logic [1:0]  op;
        endp_t       endp;
        logic [63:0] arg;                            // setup word or OUT length
        logic        ready;                          // ep81_valid on IN, ep01_ready on OUT
        pid_t        exp_pid;
        logic [4:0]  exp_cnt;
        logic [2:0]  src;
    } op_row_t;

    logic       clk;
    logic       rstn;
    rx_pkt_t    rx;
    logic       tp_byte_req;
    tx_pkt_t    tx;
    setup_cmd_u setup_cmd;
    logic [8:0] resp_idx;
    logic [7:0] user_resp;
    logic [7:0] ep81_data;
    logic       ep81_valid;
    logic       ep81_ready;
    logic [7:0] ep01_data;
    logic       ep01_valid;
    logic       ep01_ready;

    op_row_t    rows [0:NROWS-1];
    logic [7:0] got_q [$];                           // reply bytes
    logic [7:0] ep81_q [$];                          // bytes taken on ep81_ready
    logic [7:0] fwd_q [$];                           // bytes seen on ep01
    logic [7:0] sent_q [$];                          // host payload
    integer     seed;
    int         ctrl_pos;                            // position in control data stage
    logic       fwd_on;                              // ep01 readiness at last ep1 data end

    usb_txn_top #(
        .CTRL_MAXPKT (8'd8),
        .IN1_MAXPKT  (10'd8),
        .DEVICE_DESC (TB_DESC)
    ) i_usb_txn_top (
        .clk, .rstn, .rx, .tp_byte_req, .tx, .setup_cmd, .resp_idx, .user_resp,
        .ep81_data, .ep81_valid, .ep81_ready, .ep01_data, .ep01_valid, .ep01_ready
    );

    always #4 clk = ~clk;

    assign user_resp = resp_idx[7:0] ^ 8'h5a;        // user request model

    always @(negedge clk) begin
        if (rstn && ep01_valid)
            fwd_q.push_back(ep01_data);
    end

    // ------------------------------------------------------------
    // checks and expected bytes
    // ------------------------------------------------------------
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_stop("stopping at the first mismatch");
        end
    endtask

    function automatic logic [7:0] expect_byte(input logic [2:0] src, input int pos);
        logic [143:0] sh;
        sh = TB_DESC << (8 * pos);                   // wanted byte moves to the top
        case (src)
            SRC_DESC: expect_byte = (pos < 18) ? sh[143:136] : 8'h00;
            SRC_CFG:  expect_byte = (pos == 0) ? 8'h01 : 8'h00;
            SRC_USER: expect_byte = pos[7:0] ^ 8'h5a;
            default:  expect_byte = 8'h00;
        endcase
    endfunction

    function automatic op_row_t make_row(input logic [1:0] op, input endp_t endp,
                                         input logic [63:0] arg, input logic ready,
                                         input pid_t pid, input logic [4:0] cnt,
                                         input logic [2:0] src);
        make_row = {op, endp, arg, ready, pid, cnt, src};
    endfunction

    task automatic load_table();
        rows[0]  = make_row(OP_SETUP, EP_CTRL, SU_GET_DESC, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[1]  = make_row(OP_IN, EP_CTRL, 64'd0, 1'b0, PID_DATA1, 5'd8, SRC_DESC);
        rows[2]  = make_row(OP_ACK, EP_CTRL, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[3]  = make_row(OP_IN, EP_CTRL, 64'd0, 1'b0, PID_DATA0, 5'd8, SRC_DESC);
        rows[4]  = make_row(OP_ACK, EP_CTRL, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[5]  = make_row(OP_IN, EP_CTRL, 64'd0, 1'b0, PID_DATA1, 5'd2, SRC_DESC);
        rows[6]  = make_row(OP_ACK, EP_CTRL, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[7]  = make_row(OP_SETUP, EP_CTRL, SU_GET_CONFIG, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[8]  = make_row(OP_IN, EP_CTRL, 64'd0, 1'b0, PID_DATA1, 5'd4, SRC_CFG);
        rows[9]  = make_row(OP_ACK, EP_CTRL, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[10] = make_row(OP_SETUP, EP_CTRL, SU_VENDOR, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[11] = make_row(OP_IN, EP_CTRL, 64'd0, 1'b0, PID_DATA1, 5'd5, SRC_USER);
        rows[12] = make_row(OP_ACK, EP_CTRL, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[13] = make_row(OP_SETUP, EP_CTRL, SU_SET_CONFIG, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[14] = make_row(OP_IN, EP_CTRL, 64'd0, 1'b0, PID_DATA1, 5'd0, SRC_NONE);
        rows[15] = make_row(OP_ACK, EP_CTRL, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[16] = make_row(OP_IN, EP_IN1, 64'd0, 1'b0, PID_NAK, 5'd0, SRC_NONE);
        rows[17] = make_row(OP_IN, EP_IN1, 64'd0, 1'b1, PID_DATA0, 5'd8, SRC_EP81);
        rows[18] = make_row(OP_ACK, EP_IN1, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[19] = make_row(OP_IN, EP_IN1, 64'd0, 1'b1, PID_DATA1, 5'd8, SRC_EP81);
        rows[20] = make_row(OP_ACK, EP_IN1, 64'd0, 1'b0, PID_ACK, 5'd0, SRC_NONE);
        rows[21] = make_row(OP_OUT, EP_OUT1, 64'd4, 1'b0, PID_NAK, 5'd0, SRC_NONE);
        rows[22] = make_row(OP_OUT, EP_OUT1, 64'd4, 1'b1, PID_ACK, 5'd0, SRC_NONE);
        rows[23] = make_row(OP_OUT, EP_OUT1, 64'd6, 1'b1, PID_ACK, 5'd0, SRC_NONE);
        rows[24] = make_row(OP_OUT, EP_OUT1, 64'd3, 1'b0, PID_NAK, 5'd0, SRC_NONE);
        rows[25] = make_row(OP_OUT, EP_OUT1, 64'd2, 1'b1, PID_ACK, 5'd0, SRC_NONE);
    endtask

    // ------------------------------------------------------------
    // host packet model
    // ------------------------------------------------------------
    task automatic drive_rx(input pid_t pid, input endp_t endp, input logic be,
                            input logic [7:0] data, input logic fin);
        @(posedge clk);
        rx <= {pid, endp, be, data, fin, fin};       // okay follows fin, crc always good
    endtask

    task automatic send_token(input pid_t pid, input endp_t endp);
        drive_rx(pid, endp, 1'b0, 8'h00, 1'b1);
        drive_rx(4'h0, 4'h0, 1'b0, 8'h00, 1'b0);
    endtask

    task automatic send_data(input pid_t pid);
        foreach (sent_q[k])
            drive_rx(pid, 4'h0, 1'b1, sent_q[k], 1'b0);
        drive_rx(pid, 4'h0, 1'b0, 8'h00, 1'b1);
        drive_rx(4'h0, 4'h0, 1'b0, 8'h00, 1'b0);
    endtask

    task automatic wait_reply(output pid_t pid);
        int n;
        n = 0;
        @(negedge clk);
        while (!tx.sta && n < WAIT_MAX) begin
            @(negedge clk);
            n = n + 1;
        end
        if (!tx.sta)
            fail_stop("no reply packet started within 50 cycles");
        else
            pid = tx.pid;
    endtask

    // request a byte every second cycle until fin_n drops
    task automatic collect_bytes();
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        got_q.delete();
        ep81_q.delete();
        while (!done && n < BYTE_MAX) begin
            @(posedge clk);
            tp_byte_req <= 1'b1;
            ep81_data   <= 8'($random(seed));        // fresh byte offered per request
            @(negedge clk);
            if (ep81_ready)
                ep81_q.push_back(ep81_data);
            @(posedge clk);
            tp_byte_req <= 1'b0;
            @(negedge clk);
            if (tx.fin_n)
                got_q.push_back(tx.data);
            else
                done = 1'b1;
            n = n + 1;
        end
        if (!done)
            fail_stop("reply packet did not end within 64 byte requests");
    endtask

    task automatic run_row(input op_row_t r);
        pid_t       pid;
        int         len;
        logic [7:0] exp;
        sent_q.delete();
        fwd_q.delete();
        len = int'(r.arg[7:0]);
        @(posedge clk);
        ep81_valid <= (r.op == OP_IN) && r.ready;
        if (r.op == OP_OUT)
            ep01_ready <= r.ready;
        case (r.op)
            OP_SETUP: begin
                for (int k = 0; k < 8; k++)
                    sent_q.push_back(r.arg[8*k +: 8]);
                send_token(PID_SETUP, r.endp);
                send_data(PID_DATA0);
                ctrl_pos = 0;                        // new request restarts the data stage
            end
            OP_OUT: begin
                for (int k = 0; k < len; k++)
                    sent_q.push_back(8'($random(seed)));
                send_token(PID_OUT, r.endp);
                send_data(PID_DATA0);
            end
            OP_IN:   send_token(PID_IN, r.endp);
            default: send_token(PID_ACK, 4'h0);
        endcase
        if (r.op != OP_ACK) begin
            wait_reply(pid);
            check_val("tx.pid", 64'(pid), 64'(r.exp_pid));
            collect_bytes();
            check_val("tx.data count", 64'(got_q.size()), 64'(r.exp_cnt));
            if (r.src == SRC_EP81)
                check_val("ep81_ready count", 64'(ep81_q.size()), 64'(r.exp_cnt));
            foreach (got_q[k]) begin
                exp = (r.src == SRC_EP81) ? ep81_q[k] : expect_byte(r.src, ctrl_pos + k);
                check_val("tx.data", 64'(got_q[k]), 64'(exp));
            end
            if (r.op == OP_IN && r.endp == EP_CTRL) begin
                ctrl_pos = ctrl_pos + got_q.size();
                check_val("resp_idx", 64'(resp_idx), 64'(ctrl_pos));   // one step per byte
            end
        end
        if (r.op == OP_SETUP)
            check_val("setup_cmd", setup_cmd.raw, r.arg);
        if (r.op == OP_OUT) begin
            check_val("ep01_valid count", 64'(fwd_q.size()), fwd_on ? 64'(len) : 64'd0);
            if (fwd_on) begin
                foreach (fwd_q[k])
                    check_val("ep01_data", 64'(fwd_q[k]), 64'(sent_q[k]));
            end
            fwd_on = r.ready;                        // readiness at this packet end
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        clk         = 1'b0;
        rstn        = 1'b0;
        rx          = '0;
        tp_byte_req = 1'b0;
        ep81_data   = 8'h00;
        ep81_valid  = 1'b0;
        ep01_ready  = 1'b0;
        seed        = 32'h9e9ba271;
        ctrl_pos    = 0;
        fwd_on      = 1'b0;
        load_table();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);
        for (i = 0; i < NROWS; i++)
            run_row(rows[i]);
        repeat (4) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/usb_txn_pkg.sv
hdl/token_tracker.sv
hdl/ctrl_endpoint.sv
hdl/in_packet_sender.sv
hdl/out_data_router.sv
hdl/usb_txn_top.sv
bench/tb_usb_txn.sv

// ==== Makefile ====
# Verilator build and run of the USB transaction layer testbench

VERILATOR ?= verilator
TOP       ?= tb_usb_txn
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
